// ==== source/bwt_ext_pkg.sv ====
package bwt_ext_pkg;

	// ------------------------------------------------------------
	// widths and limits
	// ------------------------------------------------------------
	localparam int READ_NUM_W = 8;	// read number
	localparam int POS_W = 7;	// position, min_intv, queue pointer
	localparam int IDX_W = 64;	// one interval field
	localparam int ADDR_W = 32;	// DRAM byte address
	localparam int unsigned READ_LEN = 101;	// forward search stops here

	// ------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------
	typedef enum logic [5:0] {
		F_INIT  = 6'd0,	// first step, becomes F_RUN on the way out
		F_RUN   = 6'd1,
		F_BREAK = 6'd2,
		BCK_INI = 6'd4,	// handed over to the backward search
		BCK_RUN = 6'd5,
		BCK_END = 6'd6,
		BUBBLE  = 6'h30	// empty slot
	} fwd_status_e;

	// anything above BASE_T is an ambiguous base (N)
	typedef enum logic [7:0] {
		BASE_A = 8'd0,
		BASE_C = 8'd1,
		BASE_G = 8'd2,
		BASE_T = 8'd3
	} query_e;

	// ------------------------------------------------------------
	// payload types
	// ------------------------------------------------------------
	typedef struct packed {
		logic [IDX_W-1:0] x0;
		logic [IDX_W-1:0] x1;
		logic [IDX_W-1:0] x2;	// interval size
		logic [IDX_W-1:0] info;	// low bits hold the return position
	} bi_interval_t;

	typedef bi_interval_t [3:0] ok_set_t;	// one extended interval per base

	typedef struct packed {
		fwd_status_e status;
		query_e query;	// current base only
		logic [POS_W-1:0] ptr_curr;	// next free slot of the curr queue
		logic [READ_NUM_W-1:0] read_num;
		bi_interval_t ik;
		logic [POS_W-1:0] forward_i;
		logic [POS_W-1:0] min_intv;
		logic [POS_W-1:0] backward_x;
	} fwd_item_t;

	typedef struct packed {
		logic we;
		logic [READ_NUM_W-1:0] read_num;
		logic [POS_W-1:0] addr;
		logic [4*IDX_W-1:0] data;	// info, x2, x1, x0 from high to low
	} curr_wr_t;

	typedef struct packed {
		logic valid;
		logic [POS_W-1:0] ret;
		logic [READ_NUM_W-1:0] read_num;
	} ret_t;

	typedef struct packed {
		fwd_status_e status;
		logic [READ_NUM_W-1:0] read_num;
		logic [POS_W-1:0] position;
	} query_req_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr_k;
		logic [ADDR_W-1:0] addr_l;
	} dram_req_t;

endpackage

// ==== source/fwd_step_decide.sv ====
module fwd_step_decide import bwt_ext_pkg::*; (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  fwd_item_t item_i,
	input  ok_set_t ok_set_i,
	output fwd_item_t item_o,
	output bi_interval_t sel_ok_o,
	output logic update_ik_o,
	output logic add_i_o,
	output curr_wr_t curr_wr_o,
	output ret_t ret_o
);

	fwd_item_t item_q;	// first stage
	ok_set_t ok_q;
	bi_interval_t sel_ok;
	logic x2_changed;
	logic below_min;

	// ------------------------------------------------------------
	// stage 1: register item and candidates, read-length limit
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_q.status <= BUBBLE;
		end
		else if (!stall_i) begin
			item_q <= item_i;
			ok_q <= ok_set_i;
			if (item_i.status == F_RUN && item_i.forward_i >= READ_LEN) begin
				item_q.status <= F_BREAK;	// whole read consumed
			end
		end
	end

	// candidates are stored T..A, so base c sits at index 3 - c
	assign sel_ok = ok_q[2'd3 - item_q.query[1:0]];
	assign x2_changed = sel_ok.x2 != item_q.ik.x2;
	assign below_min = sel_ok.x2 < IDX_W'(item_q.min_intv);

	// ------------------------------------------------------------
	// stage 2: break decision, curr queue write, return report
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= BUBBLE;
			curr_wr_o.we <= 1'b0;
			ret_o.valid <= 1'b0;
			update_ik_o <= 1'b0;
			add_i_o <= 1'b0;
		end
		else if (!stall_i) begin
			item_o <= item_q;
			sel_ok_o <= sel_ok;

			// the old interval goes to the curr queue
			curr_wr_o.read_num <= item_q.read_num;
			curr_wr_o.addr <= item_q.ptr_curr;
			curr_wr_o.data <= {item_q.ik.info, item_q.ik.x2, item_q.ik.x1, item_q.ik.x0};
			curr_wr_o.we <= 1'b0;

			ret_o.ret <= item_q.ik.info[POS_W-1:0];
			ret_o.read_num <= item_q.read_num;
			ret_o.valid <= 1'b0;

			update_ik_o <= 1'b0;
			add_i_o <= 1'b0;

			case (item_q.status)
				F_RUN: begin
					case (item_q.query)
						BASE_A, BASE_C, BASE_G, BASE_T: begin
							if (x2_changed) begin
								curr_wr_o.we <= 1'b1;	// interval size changed
								item_o.ptr_curr <= item_q.ptr_curr + POS_W'(1);
							end
							if (x2_changed && below_min) begin
								item_o.status <= F_BREAK;	// too few hits left
							end
							else begin
								update_ik_o <= 1'b1;
								add_i_o <= 1'b1;
							end
						end
						default: begin	// ambiguous base ends the extension
							curr_wr_o.we <= 1'b1;
							item_o.ptr_curr <= item_q.ptr_curr + POS_W'(1);
							item_o.status <= F_BREAK;
						end
					endcase
				end
				F_BREAK: begin
					if (item_q.forward_i == READ_LEN) begin
						curr_wr_o.we <= 1'b1;	// reached the end of the read
						item_o.ptr_curr <= item_q.ptr_curr + POS_W'(1);
					end
					ret_o.valid <= 1'b1;
					item_o.status <= BCK_INI;
				end
				default: ;	// other states just pass
			endcase
		end
	end

endmodule

// ==== source/fwd_ik_update.sv ====
module fwd_ik_update import bwt_ext_pkg::*; (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  fwd_item_t item_i,
	input  bi_interval_t sel_ok_i,
	input  logic update_ik_i,
	input  logic add_i_i,
	output fwd_item_t item_o,
	output logic [IDX_W-1:0] k_pre_o,
	output logic [IDX_W-1:0] l_pre_o,
	output logic [IDX_W-1:0] k_pre_dec_o,
	output logic [IDX_W-1:0] l_pre_dec_o
);

	bi_interval_t ik_nxt;
	logic [POS_W-1:0] fwd_i_nxt;
	logic [IDX_W-1:0] k_nxt;
	logic [IDX_W-1:0] l_nxt;

	// ------------------------------------------------------------
	// new interval and position
	// ------------------------------------------------------------
	always_comb begin
		ik_nxt = item_i.ik;
		if (update_ik_i) begin
			ik_nxt.x0 = sel_ok_i.x0;
			ik_nxt.x1 = sel_ok_i.x1;
			ik_nxt.x2 = sel_ok_i.x2;
			ik_nxt.info = IDX_W'(item_i.forward_i) + IDX_W'(1);	// i + 1
		end
	end

	assign fwd_i_nxt = add_i_i ? item_i.forward_i + POS_W'(1) : item_i.forward_i;

	// occurrence lookup bounds of the next step
	assign k_nxt = ik_nxt.x1 - IDX_W'(1);
	assign l_nxt = k_nxt + ik_nxt.x2;

	// ------------------------------------------------------------
	// register, with both primary cases ready for the next stage
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= BUBBLE;
		end
		else if (!stall_i) begin
			item_o <= item_i;
			item_o.ik <= ik_nxt;
			item_o.forward_i <= fwd_i_nxt;

			k_pre_o <= k_nxt;
			l_pre_o <= l_nxt;
			k_pre_dec_o <= k_nxt - IDX_W'(1);	// used when past primary
			l_pre_dec_o <= l_nxt - IDX_W'(1);
		end
	end

endmodule

// ==== source/fwd_mem_request.sv ====
module fwd_mem_request import bwt_ext_pkg::*; (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [IDX_W-1:0] primary_i,
	input  fwd_item_t item_i,
	input  logic [IDX_W-1:0] k_pre_i,
	input  logic [IDX_W-1:0] l_pre_i,
	input  logic [IDX_W-1:0] k_pre_dec_i,
	input  logic [IDX_W-1:0] l_pre_dec_i,
	output query_req_t query_req_o,
	output dram_req_t dram_req_o,
	output fwd_item_t item_o
);

	fwd_item_t item_q;
	logic [IDX_W-1:0] k_q, l_q, k_dec_q, l_dec_q;
	logic [IDX_W-1:0] k_adj;
	logic [IDX_W-1:0] l_adj;
	dram_req_t dram_q;

	// ------------------------------------------------------------
	// stage 1: register, next query request one cycle early
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_q.status <= BUBBLE;
			query_req_o.status <= BUBBLE;
		end
		else if (!stall_i) begin
			item_q <= item_i;
			k_q <= k_pre_i;
			l_q <= l_pre_i;
			k_dec_q <= k_pre_dec_i;
			l_dec_q <= l_pre_dec_i;

			query_req_o.status <= item_i.status;
			query_req_o.read_num <= item_i.read_num;
			query_req_o.position <= item_i.forward_i;	// already updated
		end
	end

	// the primary row is not stored in the BWT
	assign k_adj = (k_q >= primary_i) ? k_dec_q : k_q;
	assign l_adj = (l_q >= primary_i) ? l_dec_q : l_q;

	// ------------------------------------------------------------
	// stage 2: DRAM request for the occurrence blocks
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			item_o.status <= BUBBLE;
			dram_q <= '0;
		end
		else if (!stall_i) begin
			if (item_q.status == F_INIT || item_q.status == F_RUN) begin
				dram_q.valid <= 1'b1;
				dram_q.addr_k <= {k_adj[34:7], 4'b0000};	// 128-entry block
				dram_q.addr_l <= {l_adj[34:7], 4'b0000};
			end
			else begin
				dram_q <= '0;	// a break needs no memory access
			end

			item_o <= item_q;
			if (item_q.status == F_INIT) begin
				item_o.status <= F_RUN;
			end
		end
	end

	// a request must never stay up while the pipe is frozen
	assign dram_req_o = stall_i ? '0 : dram_q;

endmodule

// ==== source/bwt_fwd_extend.sv ====
module bwt_fwd_extend import bwt_ext_pkg::*; (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  logic [IDX_W-1:0] primary_i,	// constant for a run
	input  fwd_item_t item_i,
	input  ok_set_t ok_set_i,	// same cycle as item_i
	output curr_wr_t curr_wr_o,
	output ret_t ret_o,
	output query_req_t query_req_o,
	output dram_req_t dram_req_o,
	output fwd_item_t item_o
);

	// ------------------------------------------------------------
	// decide -> update
	// ------------------------------------------------------------
	fwd_item_t dec_item;
	bi_interval_t dec_sel_ok;
	logic dec_update_ik;
	logic dec_add_i;

	// ------------------------------------------------------------
	// update -> memory request
	// ------------------------------------------------------------
	fwd_item_t upd_item;
	logic [IDX_W-1:0] upd_k_pre, upd_l_pre;
	logic [IDX_W-1:0] upd_k_pre_dec, upd_l_pre_dec;

	fwd_step_decide fwd_step_decide_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (item_i),
		.ok_set_i         (ok_set_i),
		.item_o           (dec_item),
		.sel_ok_o         (dec_sel_ok),
		.update_ik_o      (dec_update_ik),
		.add_i_o          (dec_add_i),
		.curr_wr_o        (curr_wr_o),
		.ret_o            (ret_o)
	);

	fwd_ik_update fwd_ik_update_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.item_i           (dec_item),
		.sel_ok_i         (dec_sel_ok),
		.update_ik_i      (dec_update_ik),
		.add_i_i          (dec_add_i),
		.item_o           (upd_item),
		.k_pre_o          (upd_k_pre),
		.l_pre_o          (upd_l_pre),
		.k_pre_dec_o      (upd_k_pre_dec),
		.l_pre_dec_o      (upd_l_pre_dec)
	);

	fwd_mem_request fwd_mem_request_i (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.primary_i        (primary_i),
		.item_i           (upd_item),
		.k_pre_i          (upd_k_pre),
		.l_pre_i          (upd_l_pre),
		.k_pre_dec_i      (upd_k_pre_dec),
		.l_pre_dec_i      (upd_l_pre_dec),
		.query_req_o      (query_req_o),
		.dram_req_o       (dram_req_o),
		.item_o           (item_o)
	);

endmodule

// ==== testbench/bwt_fwd_extend_tb.sv ====
module bwt_fwd_extend_tb import bwt_ext_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		curr_wr_t curr;
		ret_t ret;
		query_req_t query;
		dram_req_t dram;
		fwd_item_t item;
	} expect_t;

	logic Clk_32UI;
	logic reset_BWT_extend;
	logic stall_i;
	logic [IDX_W-1:0] primary_i;
	fwd_item_t item_i;
	ok_set_t ok_set_i;
	curr_wr_t curr_wr_o;
	ret_t ret_o;
	query_req_t query_req_o;
	dram_req_t dram_req_o;
	fwd_item_t item_o;

	integer seed = 74576;
	expect_t dec_q[$];	// curr write and return
	expect_t query_q[$];
	expect_t out_q[$];	// DRAM request and output item

	bwt_fwd_extend bwt_fwd_extend_i (.*);

	always #4 Clk_32UI = ~Clk_32UI;

	// ------------------------------------------------------------
	// random helpers
	// ------------------------------------------------------------
	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [IDX_W-1:0] rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// either close to primary or anywhere
	function automatic logic [IDX_W-1:0] near_primary();
		if (rand_below(4) == 0) return rand_word();
		return primary_i + IDX_W'(rand_below(9)) - IDX_W'(4);
	endfunction

	function automatic fwd_item_t make_item();
		fwd_item_t it;
		int unsigned r;
		it = '0;
		r = rand_below(16);
		if (r < 9) it.status = F_RUN;
		else if (r < 11) it.status = F_INIT;
		else if (r < 13) it.status = F_BREAK;
		else if (r == 13) it.status = BCK_RUN;
		else it.status = (r == 14) ? BCK_END : BUBBLE;
		if (rand_below(8) < 6) it.query = query_e'(rand_below(4));
		else it.query = query_e'(4 + rand_below(252));	// ambiguous base
		it.ptr_curr = POS_W'(rand_below(128));
		it.read_num = READ_NUM_W'(rand_below(256));
		r = rand_below(8);
		if (r == 0) it.forward_i = POS_W'(READ_LEN);
		else if (r == 1) it.forward_i = POS_W'(READ_LEN + rand_below(27));
		else it.forward_i = POS_W'(rand_below(READ_LEN));
		it.min_intv = POS_W'(rand_below(40));
		it.backward_x = POS_W'(rand_below(128));
		it.ik = {rand_word(), near_primary(), IDX_W'(rand_below(48)), rand_word()};
		return it;
	endfunction

	function automatic ok_set_t make_candidates(input fwd_item_t it);
		ok_set_t ok;
		int b;
		for (b = 0; b < 4; b++) begin
			ok[b] = {rand_word(), near_primary(), IDX_W'(0), rand_word()};
			case (rand_below(3))
				0: ok[b].x2 = it.ik.x2;	// size unchanged
				1: ok[b].x2 = IDX_W'(it.min_intv) + IDX_W'(rand_below(20));
				default: ok[b].x2 = IDX_W'(rand_below(int'(it.min_intv) + 1));
			endcase
		end
		return ok;
	endfunction

	// ------------------------------------------------------------
	// reference model of one extension step
	// ------------------------------------------------------------
	function automatic expect_t ref_step(input fwd_item_t it, input ok_set_t ok,
			input logic [IDX_W-1:0] prim);
		expect_t e;
		fwd_item_t w;
		bi_interval_t cand;
		logic take;
		logic [IDX_W-1:0] k;
		logic [IDX_W-1:0] l;
		e = '0;
		w = it;
		take = 1'b0;
		if (w.status == F_RUN && w.forward_i >= 7'd101) w.status = F_BREAK;
		e.curr = {1'b0, w.read_num, w.ptr_curr, w.ik.info, w.ik.x2, w.ik.x1, w.ik.x0};
		e.ret = {1'b0, w.ik.info[6:0], w.read_num};
		if (w.status == F_RUN && w.query > 8'd3) begin	// ambiguous base
			e.curr.we = 1'b1;
			w.ptr_curr = w.ptr_curr + 7'd1;
			w.status = F_BREAK;
		end
		else if (w.status == F_RUN) begin
			cand = ok[3 - int'(w.query)];
			take = 1'b1;
			if (cand.x2 != w.ik.x2) begin
				e.curr.we = 1'b1;
				w.ptr_curr = w.ptr_curr + 7'd1;
				if (cand.x2 < 64'(w.min_intv)) begin
					w.status = F_BREAK;
					take = 1'b0;
				end
			end
		end
		else if (w.status == F_BREAK) begin
			e.curr.we = (w.forward_i == 7'd101);	// end of read
			w.ptr_curr = w.ptr_curr + 7'(e.curr.we);
			e.ret.valid = 1'b1;
			w.status = BCK_INI;
		end
		if (take) begin
			w.ik = {cand.x0, cand.x1, cand.x2, 64'(w.forward_i) + 64'd1};
			w.forward_i = w.forward_i + 7'd1;
		end
		e.query = {w.status, w.read_num, w.forward_i};
		k = w.ik.x1 - 64'd1;
		l = k + w.ik.x2;
		k = (k >= prim) ? k - 64'd1 : k;	// primary row skipped
		l = (l >= prim) ? l - 64'd1 : l;
		if (w.status == F_INIT || w.status == F_RUN)
			e.dram = {1'b1, k[34:7], 4'b0000, l[34:7], 4'b0000};
		if (w.status == F_INIT) w.status = F_RUN;
		e.item = w;
		return e;
	endfunction

	function automatic expect_t bubble_expect();
		expect_t e;
		e = '0;
		e.query.status = BUBBLE;
		e.item.status = BUBBLE;
		return e;
	endfunction

	task automatic report_mismatch(input string name, input logic [319:0] exp_v,
			input logic [319:0] act_v);
		$display("Error %s: expected %h, actual %h", name, exp_v, act_v);
		$display("Test failures found");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "%s", what);
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin : drive_proc
		fwd_item_t it;
		ok_set_t ok;
		expect_t e;
		int n;
		int waited;
		Clk_32UI = 1'b0;
		reset_BWT_extend = 1'b0;
		stall_i = 1'b0;
		item_i = '0;
		item_i.status = BUBBLE;
		ok_set_i = '0;
		primary_i = rand_word() >> 20;
		e = bubble_expect();
		repeat (2) dec_q.push_back(e);	// pipe contents right after reset
		repeat (4) query_q.push_back(e);
		repeat (5) out_q.push_back(e);
		repeat (8) @(posedge Clk_32UI);
		reset_BWT_extend <= 1'b1;
		n = 0;
		while (n < 400) begin
			if (rand_below(5) == 0) begin
				stall_i <= 1'b1;
			end
			else begin
				it = make_item();
				ok = make_candidates(it);
				e = ref_step(it, ok, primary_i);
				stall_i <= 1'b0;
				item_i <= it;
				ok_set_i <= ok;
				dec_q.push_back(e);
				query_q.push_back(e);
				out_q.push_back(e);
				n++;
			end
			@(posedge Clk_32UI);
		end
		it = '0;
		it.status = BUBBLE;
		stall_i <= 1'b0;
		item_i <= it;
		waited = 0;
		while (out_q.size() != 0 && waited < 64) begin
			@(posedge Clk_32UI);
			waited++;
		end
		if (out_q.size() != 0) begin
			report_failure("timeout while waiting for the pipeline to drain");
		end
		else begin
			$display("All tests passed!");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// compare, just before each unstalled edge
	// ------------------------------------------------------------
	initial begin : compare_proc
		expect_t e;
		@(posedge Clk_32UI);
		forever begin
			@(negedge Clk_32UI);
			if (!reset_BWT_extend) begin
				assert (!curr_wr_o.we && !ret_o.valid && !dram_req_o.valid
						&& item_o.status == BUBBLE)
					else report_failure("outputs are not idle during reset");
			end
			else if (stall_i) begin
				assert (dram_req_o === '0)
					else report_mismatch("stall dram_req_o", '0, dram_req_o);
			end
			else begin
				if (dec_q.size() != 0) begin
					e = dec_q.pop_front();
					assert (curr_wr_o.we === e.curr.we && (!e.curr.we || curr_wr_o === e.curr))
						else report_mismatch("curr_wr_o", e.curr, curr_wr_o);
					assert (ret_o.valid === e.ret.valid && (!e.ret.valid || ret_o === e.ret))
						else report_mismatch("ret_o", e.ret, ret_o);
				end
				if (query_q.size() != 0) begin
					e = query_q.pop_front();
					assert (query_req_o.status === e.query.status
							&& (e.query.status == BUBBLE || query_req_o === e.query))
						else report_mismatch("query_req_o", e.query, query_req_o);
				end
				if (out_q.size() != 0) begin
					e = out_q.pop_front();
					assert (dram_req_o === e.dram)
						else report_mismatch("dram_req_o", e.dram, dram_req_o);
					assert (item_o.status === e.item.status
							&& (e.item.status == BUBBLE || item_o === e.item))
						else report_mismatch("item_o", e.item, item_o);
				end
			end
		end
	end

endmodule

// ==== files.f ====
source/bwt_ext_pkg.sv
source/fwd_step_decide.sv
source/fwd_ik_update.sv
source/fwd_mem_request.sv
source/bwt_fwd_extend.sv
testbench/bwt_fwd_extend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the forward extension testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! rm -rf obj_dir; then
	echo "could not clean obj_dir"
	exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module bwt_fwd_extend_tb -o bwt_fwd_extend_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/bwt_fwd_extend_sim; then
	echo "simulation failed"
	exit 1
fi

exit 0
